// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_back_end
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
rtl/cache_axi_conf_pkg.sv
rtl/cache_axi_bus_pkg.sv
rtl/cache_write_channel_axi.sv
rtl/cache_read_channel_axi.sv
rtl/cache_back_end_axi.sv
verif/cache_back_end_assert.sv
verif/cache_back_end_checker.sv
verif/tb_cache_back_end.sv

// File: rtl/cache_axi_bus_pkg.sv
// front-end request struct, AXI4-Lite channel structs and bundles
// and the channel engine state enum
package cache_axi_bus_pkg;

   typedef struct packed {
      logic                                       valid;
      logic [cache_axi_conf_pkg::FE_ADDR_W-1:0]   addr;
      logic [cache_axi_conf_pkg::FE_DATA_W-1:0]   wdata;
      logic [cache_axi_conf_pkg::FE_NBYTES-1:0]   wstrb;  // zero means read
   } fe_req_t;

   typedef struct packed {
      logic [cache_axi_conf_pkg::FE_ADDR_W-1:0]   awaddr;
      logic                                       awvalid;
   } axi_aw_t;

   typedef struct packed {
      logic [cache_axi_conf_pkg::BE_DATA_W-1:0]   wdata;
      logic [cache_axi_conf_pkg::BE_NBYTES-1:0]   wstrb;
      logic                                       wvalid;
   } axi_w_t;

   typedef struct packed {
      logic [cache_axi_conf_pkg::RESP_W-1:0]      bresp;
      logic                                       bvalid;
   } axi_b_t;

   typedef struct packed {
      logic [cache_axi_conf_pkg::FE_ADDR_W-1:0]   araddr;
      logic                                       arvalid;
   } axi_ar_t;

   typedef struct packed {
      logic [cache_axi_conf_pkg::BE_DATA_W-1:0]   rdata;
      logic [cache_axi_conf_pkg::RESP_W-1:0]      rresp;
      logic                                       rvalid;
   } axi_r_t;

   // master to memory
   typedef struct packed {
      axi_aw_t aw;
      axi_w_t  w;
      axi_ar_t ar;
      logic    bready;
      logic    rready;
   } axi_mosi_t;

   // memory to master
   typedef struct packed {
      logic    awready;
      logic    wready;
      logic    arready;
      axi_b_t  b;
      axi_r_t  r;
   } axi_miso_t;

   typedef enum logic [1:0] {
      CH_IDLE,
      CH_ADDR,
      CH_DATA,
      CH_RESP
   } ch_state_e;

endpackage

// File: rtl/cache_axi_conf_pkg.sv
// fixed widths of the front-end word and the AXI4-Lite data bus
// byte counts, lane select width and AXI response codes
package cache_axi_conf_pkg;

   // front-end side
   localparam int FE_ADDR_W   = 16;                // byte address, also used as AXI address
   localparam int FE_DATA_W   = 32;
   localparam int FE_NBYTES   = FE_DATA_W / 8;
   localparam int FE_NBYTES_W = $clog2(FE_NBYTES);

   // memory side
   localparam int BE_DATA_W   = 64;
   localparam int BE_NBYTES   = BE_DATA_W / 8;
   localparam int BE_NBYTES_W = $clog2(BE_NBYTES);

   // address bits above the front-end byte offset that pick the half
   localparam int LANE_W = BE_NBYTES_W - FE_NBYTES_W;  // one bit for two halves

   // response codes on bresp and rresp
   localparam int RESP_W = 2;

   localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
   localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;  // answered by the memory on a fault

endpackage

// File: rtl/cache_back_end_axi.sv
// back end top with write and read engines on one AXI4-Lite master port
// request routing and merge of ready, read data and bus outputs
`timescale 1ns/1ps

module cache_back_end_axi (
   input  logic                                      clk_i,
   input  logic                                      reset_i,
   // front end
   input  cache_axi_bus_pkg::fe_req_t                fe_req_i,
   output logic                                      fe_ready_o,
   output logic [cache_axi_conf_pkg::FE_DATA_W-1:0]  fe_rdata_o,
   // AXI4-Lite master
   output cache_axi_bus_pkg::axi_mosi_t              axi_m_o,
   input  cache_axi_bus_pkg::axi_miso_t              axi_s_i
);

   import cache_axi_conf_pkg::*;
   import cache_axi_bus_pkg::*;

   logic                   is_write;
   logic                   wr_valid, rd_valid;
   logic                   wr_ready, rd_ready;
   logic [FE_DATA_W-1:0]   rd_rdata;
   axi_aw_t                wr_aw;
   axi_w_t                 wr_w;
   logic                   wr_bready;
   axi_ar_t                rd_ar;
   logic                   rd_rready;

   assign is_write = |fe_req_i.wstrb;  // zero strobe means read
   assign wr_valid = fe_req_i.valid & is_write;
   assign rd_valid = fe_req_i.valid & ~is_write;

   cache_write_channel_axi u_write (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .valid_i   (wr_valid),
      .addr_i    (fe_req_i.addr),
      .wdata_i   (fe_req_i.wdata),
      .wstrb_i   (fe_req_i.wstrb),
      .ready_o   (wr_ready),
      .aw_o      (wr_aw),
      .w_o       (wr_w),
      .bready_o  (wr_bready),
      .awready_i (axi_s_i.awready),
      .wready_i  (axi_s_i.wready),
      .b_i       (axi_s_i.b)
   );

   cache_read_channel_axi u_read (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .valid_i   (rd_valid),
      .addr_i    (fe_req_i.addr),
      .ready_o   (rd_ready),
      .rdata_o   (rd_rdata),
      .ar_o      (rd_ar),
      .rready_o  (rd_rready),
      .arready_i (axi_s_i.arready),
      .r_i       (axi_s_i.r)
   );

   assign fe_ready_o = wr_ready | rd_ready;  // only one engine is busy at a time
   assign fe_rdata_o = rd_rdata;

   assign axi_m_o = '{aw: wr_aw, w: wr_w, ar: rd_ar, bready: wr_bready, rready: rd_rready};

endmodule

// File: rtl/cache_read_channel_axi.sv
// read engine for the AXI4-Lite bus
// address and data sequencing with retry, plus half-word select
`timescale 1ns/1ps

module cache_read_channel_axi (
   input  logic                                      clk_i,
   input  logic                                      reset_i,
   // front end
   input  logic                                      valid_i,
   input  logic [cache_axi_conf_pkg::FE_ADDR_W-1:0]  addr_i,
   output logic                                      ready_o,
   output logic [cache_axi_conf_pkg::FE_DATA_W-1:0]  rdata_o,
   // AXI4-Lite read channels
   output cache_axi_bus_pkg::axi_ar_t                ar_o,
   output logic                                      rready_o,
   input  logic                                      arready_i,
   input  cache_axi_bus_pkg::axi_r_t                 r_i
);

   import cache_axi_conf_pkg::*;
   import cache_axi_bus_pkg::*;

   ch_state_e           state;
   logic [LANE_W-1:0]   lane;
   logic                resp_ok;

   assign lane    = addr_i[FE_NBYTES_W +: LANE_W];
   assign resp_ok = r_i.rvalid & (r_i.rresp == RESP_OKAY);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= CH_IDLE;
      end else begin
         case (state)
            CH_IDLE: begin
               if (valid_i) begin
                  state <= CH_ADDR;
               end
            end
            CH_ADDR: begin
               if (arready_i) begin
                  state <= CH_RESP;  // no separate data phase on reads
               end
            end
            CH_RESP: begin
               if (resp_ok) begin
                  state <= CH_IDLE;
               end else if (r_i.rvalid) begin
                  state <= CH_ADDR;  // retry after error
               end
            end
            default: state <= CH_IDLE;
         endcase
      end
   end

   always_comb begin
      ar_o.araddr  = {addr_i[FE_ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};
      ar_o.arvalid = (state == CH_ADDR);
      rready_o     = (state == CH_RESP);
      ready_o      = (state == CH_RESP) & resp_ok;
   end

   // valid in the ready_o cycle
   assign rdata_o = r_i.rdata[lane * FE_DATA_W +: FE_DATA_W];

endmodule

// File: rtl/cache_write_channel_axi.sv
// write engine for the AXI4-Lite bus
// lane placement, strobe shift and address/data/response sequencing with retry
`timescale 1ns/1ps

module cache_write_channel_axi (
   input  logic                                      clk_i,
   input  logic                                      reset_i,
   // front end
   input  logic                                      valid_i,
   input  logic [cache_axi_conf_pkg::FE_ADDR_W-1:0]  addr_i,
   input  logic [cache_axi_conf_pkg::FE_DATA_W-1:0]  wdata_i,
   input  logic [cache_axi_conf_pkg::FE_NBYTES-1:0]  wstrb_i,
   output logic                                      ready_o,
   // AXI4-Lite write channels
   output cache_axi_bus_pkg::axi_aw_t                aw_o,
   output cache_axi_bus_pkg::axi_w_t                 w_o,
   output logic                                      bready_o,
   input  logic                                      awready_i,
   input  logic                                      wready_i,
   input  cache_axi_bus_pkg::axi_b_t                 b_i
);

   import cache_axi_conf_pkg::*;
   import cache_axi_bus_pkg::*;

   ch_state_e              state;
   logic [LANE_W-1:0]      lane;     // half of the bus word holding the front-end word
   logic [BE_NBYTES-1:0]   strb_be;
   logic                   resp_ok;

   assign lane    = addr_i[FE_NBYTES_W +: LANE_W];
   assign strb_be = BE_NBYTES'(wstrb_i) << (lane * FE_NBYTES);  // upper half moves up 4 bytes
   assign resp_ok = b_i.bvalid & (b_i.bresp == RESP_OKAY);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= CH_IDLE;
      end else begin
         case (state)
            CH_IDLE: begin
               if (valid_i) begin
                  state <= CH_ADDR;
               end
            end
            CH_ADDR: begin
               if (awready_i) begin
                  state <= CH_DATA;  // address accepted
               end
            end
            CH_DATA: begin
               if (wready_i) begin
                  state <= CH_RESP;  // data accepted
               end
            end
            CH_RESP: begin
               if (resp_ok) begin
                  state <= CH_IDLE;
               end else if (b_i.bvalid) begin
                  // error response resends address and data
                  state <= CH_ADDR;
               end
            end
            default: state <= CH_IDLE;
         endcase
      end
   end

   // the request is held by the front end, so the payload follows it directly
   always_comb begin
      aw_o.awaddr  = {addr_i[FE_ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};  // 8-byte aligned
      aw_o.awvalid = (state == CH_ADDR);

      w_o.wdata    = {(BE_DATA_W / FE_DATA_W){wdata_i}};  // same word in both lanes
      w_o.wstrb    = strb_be;
      w_o.wvalid   = (state == CH_DATA);

      bready_o     = (state == CH_RESP);
      ready_o      = (state == CH_RESP) & resp_ok;  // one-cycle completion pulse
   end

endmodule

// File: verif/cache_back_end_assert.sv
// handshake assertions for the back end top, attached with bind
`timescale 1ns/1ps

module cache_back_end_assert (
   input logic                          clk_i,
   input logic                          reset_i,
   input logic                          fe_ready_o,
   input cache_axi_bus_pkg::axi_mosi_t  axi_m_o,
   input cache_axi_bus_pkg::axi_miso_t  axi_s_i
);

   import cache_axi_bus_pkg::*;

   int fail_cnt = 0;  // assertion failures so far

   a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_m_o.aw.awvalid && !axi_s_i.awready |=> axi_m_o.aw.awvalid && $stable(axi_m_o.aw.awaddr))
      else begin
         $error("awvalid dropped or awaddr changed before awready");
         fail_cnt++;
      end

   a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_m_o.w.wvalid && !axi_s_i.wready |=> axi_m_o.w.wvalid && $stable(axi_m_o.w.wdata))
      else begin
         $error("wvalid dropped or wdata changed before wready");
         fail_cnt++;
      end

   a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_m_o.ar.arvalid && !axi_s_i.arready |=> axi_m_o.ar.arvalid && $stable(axi_m_o.ar.araddr))
      else begin
         $error("arvalid dropped or araddr changed before arready");
         fail_cnt++;
      end

   a_reset_idle: assert property (@(posedge clk_i)
      reset_i |-> !(axi_m_o.aw.awvalid || axi_m_o.w.wvalid || axi_m_o.ar.arvalid
                    || axi_m_o.bready || axi_m_o.rready || fe_ready_o))
      else begin
         $error("valid or ready output high during reset");
         fail_cnt++;
      end

   a_ready_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      fe_ready_o |=> !fe_ready_o)
      else begin
         $error("fe_ready_o high for more than one cycle");
         fail_cnt++;
      end

   a_one_resp: assert property (@(posedge clk_i) disable iff (reset_i)
      !(axi_m_o.bready && axi_m_o.rready))
      else begin
         $error("bready and rready high together");
         fail_cnt++;
      end

endmodule

bind cache_back_end_axi cache_back_end_assert u_assert (
   .clk_i      (clk_i),
   .reset_i    (reset_i),
   .fe_ready_o (fe_ready_o),
   .axi_m_o    (axi_m_o),
   .axi_s_i    (axi_s_i)
);

// File: verif/cache_back_end_checker.sv
// checker for the back end: reference memory from AXI writes, lane and read data checks
// retry counts at the fault address and completion pulse count
`timescale 1ns/1ps

module cache_back_end_checker (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  cache_axi_bus_pkg::fe_req_t    fe_req_i,
   input  logic                          fe_ready_o,
   input  logic [31:0]                   fe_rdata_o,
   input  cache_axi_bus_pkg::axi_mosi_t  axi_m_o,
   input  cache_axi_bus_pkg::axi_miso_t  axi_s_i,
   input  logic [31:0]                   exp_rdata_i,  // table value for reads
   input  int                            n_rows_i,
   input  logic                          done_i,
   output int                            mismatch_cnt_o,
   output int                            other_cnt_o
);

   import cache_axi_conf_pkg::*;
   import cache_axi_bus_pkg::*;

   logic [63:0] ref_mem [logic [15:0]];
   logic [15:0] wa;
   logic [63:0] wd;
   logic [7:0]  ws;
   logic [63:0] word;
   logic [31:0] exp;
   logic [7:0]  exp_strb;
   int          pulses, aw_at_fault, ar_at_fault;
   bit          final_done;

   initial begin
      mismatch_cnt_o = 0;
      other_cnt_o    = 0;
      pulses         = 0;
      aw_at_fault    = 0;
      ar_at_fault    = 0;
   end

   always @(posedge clk_i) begin
      if (!reset_i) begin
         if (axi_m_o.aw.awvalid && axi_s_i.awready) begin
            wa = axi_m_o.aw.awaddr;
            if (wa == 16'h0040) aw_at_fault++;
            if (wa != {fe_req_i.addr[15:3], 3'b000}) begin
               $display("MISMATCH awaddr: expected %h got %h", {fe_req_i.addr[15:3], 3'b000}, wa);
               mismatch_cnt_o++;
            end
         end
         if (axi_m_o.w.wvalid && axi_s_i.wready) begin
            wd       = axi_m_o.w.wdata;
            ws       = axi_m_o.w.wstrb;
            exp_strb = fe_req_i.addr[2] ? {fe_req_i.wstrb, 4'h0} : {4'h0, fe_req_i.wstrb};
            if (wd != {2{fe_req_i.wdata}}) begin
               $display("MISMATCH wdata: expected %h got %h", {2{fe_req_i.wdata}}, wd);
               mismatch_cnt_o++;
            end
            if (ws != exp_strb) begin
               $display("MISMATCH wstrb: expected %h got %h", exp_strb, ws);
               mismatch_cnt_o++;
            end
         end
         if (axi_m_o.ar.arvalid && axi_s_i.arready) begin
            if (axi_m_o.ar.araddr == 16'h0040) ar_at_fault++;
            if (axi_m_o.ar.araddr != {fe_req_i.addr[15:3], 3'b000}) begin
               $display("MISMATCH araddr: expected %h got %h",
                        {fe_req_i.addr[15:3], 3'b000}, axi_m_o.ar.araddr);
               mismatch_cnt_o++;
            end
         end
         // merge bytes only once the memory has accepted the write
         if (axi_s_i.b.bvalid && axi_m_o.bready && axi_s_i.b.bresp == RESP_OKAY) begin
            word = ref_mem.exists(wa) ? ref_mem[wa] : {4{wa}};
            for (int i = 0; i < 8; i++)
               if (ws[i]) word[i*8 +: 8] = wd[i*8 +: 8];
            ref_mem[wa] = word;
         end
         if (fe_ready_o) begin
            pulses++;
            if (fe_req_i.wstrb != 0) begin
               if (!(axi_s_i.b.bvalid && axi_s_i.b.bresp == RESP_OKAY)) begin
                  $display("fe_ready_o pulsed on a write without an OKAY write response");
                  other_cnt_o++;
               end
            end else begin
               if (!(axi_s_i.r.rvalid && axi_s_i.r.rresp == RESP_OKAY)) begin
                  $display("fe_ready_o pulsed on a read without an OKAY read response");
                  other_cnt_o++;
               end
               word = ref_mem.exists({fe_req_i.addr[15:3], 3'b000}) ?
                      ref_mem[{fe_req_i.addr[15:3], 3'b000}] : {4{fe_req_i.addr[15:3], 3'b000}};
               exp  = fe_req_i.addr[2] ? word[63:32] : word[31:0];
               if (fe_rdata_o != exp || fe_rdata_o != exp_rdata_i) begin
                  $display("MISMATCH fe_rdata_o: expected %h (table %h) got %h",
                           exp, exp_rdata_i, fe_rdata_o);
                  mismatch_cnt_o++;
               end
            end
         end
         if (done_i && !final_done) begin
            final_done = 1;
            if (pulses != n_rows_i) begin
               $display("saw %0d completion pulses for %0d requests", pulses, n_rows_i);
               other_cnt_o++;
            end
            if (aw_at_fault != 2 || ar_at_fault != 2) begin
               $display("fault address retried wrongly: %0d AW and %0d AR handshakes",
                        aw_at_fault, ar_at_fault);
               other_cnt_o++;
            end
         end
      end
   end

endmodule

// File: verif/tb_cache_back_end.sv
// testbench top: clock, reset, request table, AXI4-Lite memory with random stalls
// and the run watchdog
`timescale 1ns/1ps

module tb_cache_back_end;

   import cache_axi_conf_pkg::*;
   import cache_axi_bus_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int N_ROWS       = 13;

   typedef struct packed {
      bit          is_wr;
      logic [15:0] addr;
      logic [31:0] data;   // write data, or expected read data
      logic [3:0]  strb;
   } row_t;

   row_t        rows [N_ROWS] = '{
      '{1'b1, 16'h0010, 32'hA5A51234, 4'hF},
      '{1'b0, 16'h0010, 32'hA5A51234, 4'h0},
      '{1'b0, 16'h0014, 32'h00100010, 4'h0},  // unwritten, fill value
      '{1'b1, 16'h0024, 32'hCAFEF00D, 4'hF},  // upper half
      '{1'b0, 16'h0020, 32'h00200020, 4'h0},
      '{1'b0, 16'h0024, 32'hCAFEF00D, 4'h0},
      '{1'b1, 16'h0024, 32'h11223344, 4'h5},  // bytes 0 and 2 only
      '{1'b0, 16'h0024, 32'hCA22F044, 4'h0},
      '{1'b1, 16'h0040, 32'hDEADBEEF, 4'hF},  // first try gets SLVERR
      '{1'b0, 16'h0040, 32'hDEADBEEF, 4'h0},  // first try gets SLVERR
      '{1'b1, 16'h0030, 32'h55667788, 4'h8},
      '{1'b0, 16'h0030, 32'h55300030, 4'h0},
      '{1'b0, 16'h0034, 32'h00300030, 4'h0}
   };

   logic        clk_i, reset_i, fe_ready_o, done;
   logic [31:0] fe_rdata_o, exp_rdata;
   fe_req_t     fe_req;
   axi_mosi_t   axi_m;
   axi_miso_t   axi_s;
   int          seed = 21936;
   int          mismatch_cnt, other_cnt;
   logic [63:0] mem [logic [15:0]];
   logic [15:0] wr_addr;
   logic [1:0]  b_code, r_code;
   logic [63:0] r_data;
   int          aw_wait, w_wait, b_wait, ar_wait, r_wait;
   bit          b_pend, r_pend, wr_err_done, rd_err_done;

   function automatic int stall();
      return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
   endfunction

   function automatic logic [63:0] mem_read(logic [15:0] a);
      return mem.exists(a) ? mem[a] : {4{a}};
   endfunction

   cache_back_end_axi uut (
      .clk_i(clk_i), .reset_i(reset_i), .fe_req_i(fe_req), .fe_ready_o(fe_ready_o),
      .fe_rdata_o(fe_rdata_o), .axi_m_o(axi_m), .axi_s_i(axi_s)
   );

   cache_back_end_checker u_checker (
      .clk_i(clk_i), .reset_i(reset_i), .fe_req_i(fe_req), .fe_ready_o(fe_ready_o),
      .fe_rdata_o(fe_rdata_o), .axi_m_o(axi_m), .axi_s_i(axi_s), .exp_rdata_i(exp_rdata),
      .n_rows_i(N_ROWS), .done_i(done), .mismatch_cnt_o(mismatch_cnt), .other_cnt_o(other_cnt)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // memory write side
   always @(posedge clk_i) begin
      if (reset_i) begin
         axi_s.awready <= 0;
         axi_s.wready  <= 0;
         axi_s.b       <= '0;
         b_pend        <= 0;
      end else begin
         if (axi_s.awready && axi_m.aw.awvalid) begin
            axi_s.awready <= 0;
            wr_addr       <= axi_m.aw.awaddr;
            aw_wait       <= stall();
         end else if (axi_m.aw.awvalid) begin
            if (aw_wait == 0) axi_s.awready <= 1;
            else aw_wait <= aw_wait - 1;
         end
         if (axi_s.wready && axi_m.w.wvalid) begin
            axi_s.wready <= 0;
            w_wait       <= stall();
            b_wait       <= stall();
            b_pend       <= 1;
            if (wr_addr == 16'h0040 && !wr_err_done) begin
               b_code      <= RESP_SLVERR;
               wr_err_done <= 1;
            end else begin
               b_code <= RESP_OKAY;
               mem[wr_addr] = mem_read(wr_addr);
               for (int i = 0; i < 8; i++)
                  if (axi_m.w.wstrb[i]) mem[wr_addr][i*8 +: 8] = axi_m.w.wdata[i*8 +: 8];
            end
         end else if (axi_m.w.wvalid) begin
            if (w_wait == 0) axi_s.wready <= 1;
            else w_wait <= w_wait - 1;
         end
         if (axi_s.b.bvalid && axi_m.bready) begin
            axi_s.b.bvalid <= 0;
         end else if (b_pend) begin
            if (b_wait == 0) begin
               axi_s.b <= '{bresp: b_code, bvalid: 1'b1};
               b_pend  <= 0;
            end else b_wait <= b_wait - 1;
         end
      end
   end

   // memory read side
   always @(posedge clk_i) begin
      if (reset_i) begin
         axi_s.arready <= 0;
         axi_s.r       <= '0;
         r_pend        <= 0;
      end else begin
         if (axi_s.arready && axi_m.ar.arvalid) begin
            axi_s.arready <= 0;
            ar_wait       <= stall();
            r_wait        <= stall();
            r_pend        <= 1;
            r_data        <= mem_read(axi_m.ar.araddr);
            if (axi_m.ar.araddr == 16'h0040 && !rd_err_done) begin
               r_code      <= RESP_SLVERR;
               rd_err_done <= 1;
            end else r_code <= RESP_OKAY;
         end else if (axi_m.ar.arvalid) begin
            if (ar_wait == 0) axi_s.arready <= 1;
            else ar_wait <= ar_wait - 1;
         end
         if (axi_s.r.rvalid && axi_m.rready) begin
            axi_s.r.rvalid <= 0;
         end else if (r_pend) begin
            if (r_wait == 0) begin
               axi_s.r <= '{rdata: r_data, rresp: r_code, rvalid: 1'b1};
               r_pend  <= 0;
            end else r_wait <= r_wait - 1;
         end
      end
   end

   task automatic drive_row(int i);
      fe_req    <= '{valid: 1'b1, addr: rows[i].addr, wdata: rows[i].data,
                     wstrb: rows[i].is_wr ? rows[i].strb : 4'h0};
      exp_rdata <= rows[i].data;
   endtask

   initial begin
      clk_i     = 0;
      reset_i   = 1;
      done      = 0;
      fe_req    = '0;
      exp_rdata = '0;
      axi_s     = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      reset_i <= 0;
      @(posedge clk_i);
      drive_row(0);
      for (int i = 0; i < N_ROWS; i++) begin
         do @(posedge clk_i); while (!fe_ready_o);
         if (i + 1 < N_ROWS) drive_row(i + 1);  // next request right after the pulse
         else fe_req.valid <= 0;
      end
      done <= 1;
      repeat (3) @(posedge clk_i);
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatch_cnt, other_cnt, uut.u_assert.fail_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0 && uut.u_assert.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((N_ROWS * 40 + RESET_CYCLES) * CLK_PERIOD);
      $display("timeout: requests did not all complete in time");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule
